//--- fetch.f
+incdir+source
source/fetch_pkg.sv
source/cache_if.sv
source/fetch_ctrl.sv
source/pc_counter.sv
source/miss_timer.sv
source/icache.sv
source/fetch_top.sv
sim/fetch_chk.sv
sim/fetch_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
verilator --binary --timing --assert -f fetch.f --top-module fetch_tb -o fetch_sim \
    && { out=$(./obj_dir/fetch_sim); printf '%s\n' "$out"; \
         printf '%s\n' "$out" | grep -qx '>>> PASS'; } \
    && echo "run_sim: passed" \
    || { echo "run_sim: failed"; exit 1; }

//--- sim/fetch_chk.sv
`timescale 1ns/100ps
`include "fetch_cfg.svh"

module fetch_chk (
    input logic                    i_clk,
    input logic                    i_reset,
    input logic                    i_req,
    input logic                    i_done,
    input logic                    i_mem_req,
    input fetch_pkg::fetch_state_e i_state,
    input logic                    i_ready,
    input logic                    i_out_done
);

    logic [7:0] run_len;
    logic       accept;

    // Pipeline takes the word in IF_WAIT
    assign accept = (i_state == fetch_pkg::IF_WAIT) && i_ready;

    // Length of the current memory request burst
    always_ff @(posedge i_clk, posedge i_reset) begin
        if (i_reset) begin
            run_len <= '0;
        end else if (i_mem_req) begin
            run_len <= run_len + 8'd1;
        end else begin
            run_len <= '0;
        end
    end

    ////////////////////////////////////////
    // Properties
    ////////////////////////////////////////

    a_done_needs_req: assert property (@(posedge i_clk) disable iff (i_reset)
        $rose(i_done) |-> i_req)
        else $error("cache done rose without a request");

    a_refill_length: assert property (@(posedge i_clk) disable iff (i_reset)
        $fell(i_mem_req) |-> (run_len == 8'(`FETCH_MISS_CYCLES)))
        else $error("memory request length %0d", run_len);

    a_done_drops: assert property (@(posedge i_clk) disable iff (i_reset)
        accept |=> !i_out_done)
        else $error("o_done still high after acceptance");

endmodule

// Controller side, no memory port here
bind fetch_ctrl fetch_chk u_ctrl_chk (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_req      (cache.req),
    .i_done     (cache.done),
    .i_mem_req  (1'b0),
    .i_state    (state_q),
    .i_ready    (i_pipeline_ready),
    .i_out_done (o_done)
);

// Cache side, no pipeline handshake here
bind icache fetch_chk u_cache_chk (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_req      (cache.req),
    .i_done     (cache.done),
    .i_mem_req  (o_mem_req),
    .i_state    (fetch_pkg::IF_RESET),
    .i_ready    (1'b0),
    .i_out_done (1'b0)
);

//--- sim/fetch_stimulus.txt
# M byte_addr word : memory image
# F stall pc_load ext_pc exp_pc exp_instr exp_miss (hex) ; H window : halt, no o_done
M 00000100 00000013
M 00000104 00100093
M 00000108 00200113
M 0000010C 00300193
M 00000110 00100073
M 00000114 00800413
M 00000120 00500293
M 00000124 00600313
M 00000140 00700393
F 0 0 00000000 00000100 00000013 1
F 0 0 00000000 00000104 00100093 1
F 3 0 00000000 00000108 00200113 1
F 0 1 00000105 0000010C 00300193 1
F 1 0 00000000 00000104 00100093 0
F 0 1 00000120 00000108 00200113 0
F 2 0 00000000 00000120 00500293 1
F 0 1 00000141 00000124 00600313 1
F 0 1 00000100 00000140 00700393 1
F 0 0 00000000 00000100 00000013 1
F 0 1 0000010D 00000104 00100093 0
F 0 0 00000000 0000010C 00300193 0
F 2 0 00000000 00000110 00100073 1
H 28

//--- sim/fetch_tb.sv
`timescale 1ns/100ps

module fetch_tb;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int DRIVE_DLY    = 1;
    localparam int TIMEOUT      = 50;
    localparam int MEM_WORDS    = 256;

    logic             i_clk = 1'b0;
    logic             i_reset;
    logic             i_pipeline_ready;
    logic             i_pc_load;
    fetch_pkg::word_t i_ext_pc;
    fetch_pkg::word_t o_pc;
    fetch_pkg::word_t o_instruction;
    logic             o_done;
    logic             o_halted;
    logic             o_mem_req;
    fetch_pkg::word_t o_mem_addr;
    fetch_pkg::word_t mem_data = '0;

    // Backing memory, indexed by word address
    fetch_pkg::word_t mem [MEM_WORDS];
    // Word address of the latest refill request
    fetch_pkg::word_t last_mem_addr = '0;
    int               mem_req_cycles = 0;
    int               req_mark;
    int               checks = 0;
    int               errors = 0;
    bit               aborted = 1'b0;

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    fetch_top i_fetch_top (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_pipeline_ready (i_pipeline_ready),
        .i_pc_load        (i_pc_load),
        .i_ext_pc         (i_ext_pc),
        .o_pc             (o_pc),
        .o_instruction    (o_instruction),
        .o_done           (o_done),
        .o_halted         (o_halted),
        .o_mem_req        (o_mem_req),
        .o_mem_addr       (o_mem_addr),
        .i_mem_data       (mem_data)
    );

    ////////////////////////////////////////
    // Memory model
    ////////////////////////////////////////

    // Word served during the whole refill
    always @(posedge i_clk) begin
        #DRIVE_DLY;
        if (o_mem_req) begin
            mem_data      = mem[o_mem_addr[7:0]];
            last_mem_addr = o_mem_addr;
        end
    end

    // Refill cycles counted away from the edge
    always @(negedge i_clk) begin
        if (o_mem_req === 1'b1) begin
            mem_req_cycles <= mem_req_cycles + 1;
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    task automatic compare_word(input string name, input fetch_pkg::word_t got,
                                input fetch_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic wait_for_done(output bit got);
        int cycles;
        got    = 1'b0;
        cycles = 0;
        while (!got && cycles < TIMEOUT) begin
            @(posedge i_clk);
            #DRIVE_DLY;
            got = (o_done === 1'b1);
            cycles++;
        end
        if (!got) begin
            errors++;
            aborted = 1'b1;
            $display("Timeout at %0t: no o_done within %0d cycles", $time, TIMEOUT);
        end
    endtask

    // One fetch: check it, stall, then accept with an optional branch
    task automatic fetch_and_accept(input fetch_pkg::word_t stall, input fetch_pkg::word_t load,
                                    input fetch_pkg::word_t ext, input fetch_pkg::word_t exp_pc,
                                    input fetch_pkg::word_t exp_instr,
                                    input fetch_pkg::word_t exp_miss);
        bit               got;
        fetch_pkg::word_t held;
        wait_for_done(got);
        if (got) begin
            compare_word("o_pc", o_pc, exp_pc);
            compare_word("o_instruction", o_instruction, exp_instr);
            compare_word("o_instruction vs memory", o_instruction, mem[exp_pc[9:2]]);
            // Hits must not touch memory
            compare_bit("o_mem_req seen", mem_req_cycles != req_mark, exp_miss[0]);
            // Refill asks for the word address of the PC
            if (exp_miss[0]) begin
                compare_word("o_mem_addr", last_mem_addr, exp_pc >> 2);
            end
            held = o_instruction;
            repeat (stall) begin
                @(posedge i_clk);
                #DRIVE_DLY;
                compare_bit("o_done", o_done, 1'b1);
                compare_word("o_instruction", o_instruction, held);
            end
            i_pipeline_ready = 1'b1;
            i_pc_load        = load[0];
            i_ext_pc         = ext;
            @(posedge i_clk);
            #DRIVE_DLY;
            i_pipeline_ready = 1'b0;
            compare_bit("o_done", o_done, 1'b0);
            req_mark = mem_req_cycles;
            // Load stays up through the PC update cycle
            @(posedge i_clk);
            #DRIVE_DLY;
            i_pc_load = 1'b0;
            i_ext_pc  = '0;
        end
    endtask

    task automatic expect_halt(input fetch_pkg::word_t window);
        int cycles;
        cycles = 0;
        while (o_halted !== 1'b1 && cycles < TIMEOUT) begin
            @(posedge i_clk);
            #DRIVE_DLY;
            cycles++;
        end
        if (o_halted !== 1'b1) begin
            errors++;
            aborted = 1'b1;
            $display("Timeout at %0t: o_halted never rose", $time);
        end else begin
            repeat (window) begin
                @(posedge i_clk);
                #DRIVE_DLY;
                compare_bit("o_done", o_done, 1'b0);
                compare_bit("o_halted", o_halted, 1'b1);
            end
        end
    endtask

    ////////////////////////////////////////
    // Main flow
    ////////////////////////////////////////

    initial begin : main_flow
        int               fd;
        int               code;
        string            line;
        logic [7:0]       cmd;
        fetch_pkg::word_t a, b, c, d, e, f;
        i_reset          = 1'b1;
        i_pipeline_ready = 1'b0;
        i_pc_load        = 1'b0;
        i_ext_pc         = '0;
        // Unlisted words read back as the inverted byte address
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = ~(fetch_pkg::word_t'(i) << 2);
        end
        repeat (RESET_CYCLES) @(posedge i_clk);
        #DRIVE_DLY;
        i_reset  = 1'b0;
        req_mark = mem_req_cycles;
        fd = $fopen("sim/fetch_stimulus.txt", "r");
        if (fd == 0) begin
            errors++;
            aborted = 1'b1;
            $display("Could not open the stimulus file");
        end
        while (!aborted && fd != 0 && !$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0 && line.getc(0) != "#") begin
                code = $sscanf(line, "%c %h %h %h %h %h %h", cmd, a, b, c, d, e, f);
                case (cmd)
                    "M": mem[a[9:2]] = b;
                    "F": fetch_and_accept(a, b, c, d, e, f);
                    "H": expect_halt(a);
                    default: ;
                endcase
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- source/cache_if.sv
`timescale 1ns/100ps

interface cache_if;

    // Fetch request, high for the whole IF_FETCH state
    logic                   req;
    // Current PC, stable while req is high
    fetch_pkg::fetch_addr_u addr;
    // One-cycle answer from the cache
    logic                   done;
    // Instruction word, valid with done
    fetch_pkg::word_t       data;

    // FSM side
    modport ctrl (
        output req,
        input  done,
        input  data
    );

    // Program counter side
    modport pc (
        output addr
    );

    // Cache side
    modport cache (
        input  req,
        input  addr,
        output done,
        output data
    );

endinterface

//--- source/fetch_cfg.svh
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// Data and address width
`define FETCH_XLEN 32

// First PC after reset
`define FETCH_RESET_VECTOR 32'h0000_0100

// PC step in bytes
`define FETCH_WORD_BYTES 4

// Direct-mapped cache depth, one word per line
`define FETCH_CACHE_LINES 16

// Refill latency in cycles
`define FETCH_MISS_CYCLES 4

// Ebreak encoding stops the fetch stage
`define FETCH_HALT_WORD 32'h0010_0073

`endif

//--- source/fetch_ctrl.sv
`timescale 1ns/100ps
`include "fetch_cfg.svh"

module fetch_ctrl (
    input  logic             i_clk,
    input  logic             i_reset,
    input  logic             i_pipeline_ready,
    cache_if.ctrl            cache,
    output logic             o_done,
    output fetch_pkg::word_t o_instruction,
    output logic             o_step,
    output logic             o_halted
);

    fetch_pkg::fetch_state_e state_q;
    fetch_pkg::fetch_state_e state_d;
    logic                    accept;
    logic                    is_halt;

    // Pipeline takes the held word
    assign accept  = (state_q == fetch_pkg::IF_WAIT) && i_pipeline_ready;
    // Held word is the ebreak encoding
    assign is_halt = (o_instruction == `FETCH_HALT_WORD);

    ////////////////////////////////////////
    // State register
    ////////////////////////////////////////

    always_ff @(posedge i_clk, posedge i_reset) begin
        if (i_reset) begin
            state_q <= fetch_pkg::IF_RESET;
        end else begin
            state_q <= state_d;
        end
    end

    // Next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            fetch_pkg::IF_RESET: begin
                // PC already sits on the reset vector
                state_d = fetch_pkg::IF_FETCH;
            end
            fetch_pkg::IF_FETCH: begin
                // Stay until the cache answers
                if (cache.done) begin
                    state_d = fetch_pkg::IF_WAIT;
                end
            end
            fetch_pkg::IF_WAIT: begin
                // Halt word stops fetching once taken
                if (accept) begin
                    state_d = is_halt ? fetch_pkg::IF_HALT : fetch_pkg::IF_NEXT;
                end
            end
            fetch_pkg::IF_NEXT: begin
                state_d = fetch_pkg::IF_FETCH;
            end
            fetch_pkg::IF_HALT: begin
                // Only reset leaves this state
                state_d = fetch_pkg::IF_HALT;
            end
            default: begin
                state_d = fetch_pkg::IF_HALT;
            end
        endcase
    end

    ////////////////////////////////////////
    // Outputs to cache, PC and pipeline
    ////////////////////////////////////////

    assign cache.req = (state_q == fetch_pkg::IF_FETCH);
    // PC moves for one cycle only
    assign o_step    = (state_q == fetch_pkg::IF_NEXT);
    assign o_halted  = (state_q == fetch_pkg::IF_HALT);

    // Done flag set by cache answer, cleared by acceptance
    always_ff @(posedge i_clk, posedge i_reset) begin
        if (i_reset) begin
            o_done <= 1'b0;
        end else if (cache.done && cache.req) begin
            o_done <= 1'b1;
        end else if (accept) begin
            o_done <= 1'b0;
        end
    end

    // Instruction captured with the cache answer and held through stalls
    always_ff @(posedge i_clk) begin
        if (cache.done && cache.req) begin
            o_instruction <= cache.data;
        end
    end

endmodule

//--- source/fetch_pkg.sv
`include "fetch_cfg.svh"

package fetch_pkg;

    ////////////////////////////////////////
    // Fetch address layout
    ////////////////////////////////////////

    // Byte offset inside one word
    localparam int OFFSET_W = $clog2(`FETCH_WORD_BYTES);
    // Line select of the direct-mapped cache
    localparam int INDEX_W  = $clog2(`FETCH_CACHE_LINES);
    // Whatever is left of the address is tag
    localparam int TAG_W    = `FETCH_XLEN - INDEX_W - OFFSET_W;

    // Instruction or address word
    typedef logic [`FETCH_XLEN-1:0] word_t;

    // Cache view of an address
    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } fetch_addr_fields_t;

    // Same bits read as raw PC or as cache fields
    typedef union packed {
        word_t              raw;
        fetch_addr_fields_t f;
    } fetch_addr_u;

    ////////////////////////////////////////
    // Fetch FSM states
    ////////////////////////////////////////

    typedef enum logic [2:0] {
        IF_RESET,
        IF_FETCH,
        IF_WAIT,
        IF_NEXT,
        IF_HALT
    } fetch_state_e;

endpackage

//--- source/fetch_top.sv
`timescale 1ns/100ps
`include "fetch_cfg.svh"

module fetch_top (
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  logic                   i_pipeline_ready,
    input  logic                   i_pc_load,
    input  logic [`FETCH_XLEN-1:0] i_ext_pc,
    output logic [`FETCH_XLEN-1:0] o_pc,
    output logic [`FETCH_XLEN-1:0] o_instruction,
    output logic                   o_done,
    output logic                   o_halted,
    output logic                   o_mem_req,
    output logic [`FETCH_XLEN-1:0] o_mem_addr,
    input  logic [`FETCH_XLEN-1:0] i_mem_data
);

    // PC step request from the FSM
    logic step;

    // Request and response between FSM, PC and cache
    cache_if u_bus ();

    ////////////////////////////////////////
    // Fetch FSM
    ////////////////////////////////////////

    fetch_ctrl u_fetch_ctrl (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_pipeline_ready (i_pipeline_ready),
        .cache            (u_bus.ctrl),
        .o_done           (o_done),
        .o_instruction    (o_instruction),
        .o_step           (step),
        .o_halted         (o_halted)
    );

    ////////////////////////////////////////
    // Program counter
    ////////////////////////////////////////

    pc_counter u_pc_counter (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_step    (step),
        .i_pc_load (i_pc_load),
        .i_ext_pc  (i_ext_pc),
        .cache     (u_bus.pc),
        .o_pc      (o_pc)
    );

    ////////////////////////////////////////
    // Instruction cache
    ////////////////////////////////////////

    icache u_icache (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .cache      (u_bus.cache),
        .o_mem_req  (o_mem_req),
        .o_mem_addr (o_mem_addr),
        .i_mem_data (i_mem_data)
    );

endmodule

//--- source/icache.sv
`timescale 1ns/100ps
`include "fetch_cfg.svh"

module icache (
    input  logic             i_clk,
    input  logic             i_reset,
    cache_if.cache           cache,
    output logic             o_mem_req,
    output fetch_pkg::word_t o_mem_addr,
    input  fetch_pkg::word_t i_mem_data
);

    localparam int LINES = `FETCH_CACHE_LINES;

    // Line storage
    fetch_pkg::word_t              data_mem [LINES];
    logic [fetch_pkg::TAG_W-1:0]   tag_mem  [LINES];
    logic [LINES-1:0]              valid_q;

    // Address fields of the current request
    logic [fetch_pkg::TAG_W-1:0]   req_tag;
    logic [fetch_pkg::INDEX_W-1:0] req_index;

    logic                          hit;
    logic                          hit_accept;
    logic                          start_refill;
    logic                          refill_busy;
    logic                          refill_done;
    logic                          done_q;
    fetch_pkg::word_t              data_q;

    ////////////////////////////////////////
    // Lookup
    ////////////////////////////////////////

    assign req_tag   = cache.addr.f.tag;
    assign req_index = cache.addr.f.index;

    // Valid line with matching tag
    assign hit = valid_q[req_index] && (tag_mem[req_index] == req_tag);

    // New request, no answer given yet
    assign hit_accept   = cache.req && hit && !done_q;
    // Miss starts the timer once
    assign start_refill = cache.req && !hit && !done_q && !refill_busy;

    ////////////////////////////////////////
    // Refill from memory
    ////////////////////////////////////////

    miss_timer u_miss_timer (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_start   (start_refill),
        .o_busy    (refill_busy),
        .o_expired (refill_done)
    );

    // Memory request covers every timer cycle
    assign o_mem_req  = refill_busy;
    // Word address, offset bits dropped
    assign o_mem_addr = cache.addr.raw >> fetch_pkg::OFFSET_W;

    // Valid bits
    always_ff @(posedge i_clk, posedge i_reset) begin
        if (i_reset) begin
            valid_q <= '0;
        end else if (refill_done) begin
            valid_q[req_index] <= 1'b1;
        end
    end

    // Data and tag written in the refill_done cycle
    always_ff @(posedge i_clk) begin
        if (refill_done) begin
            data_mem[req_index] <= i_mem_data;
            tag_mem[req_index]  <= req_tag;
        end
    end

    ////////////////////////////////////////
    // Response
    ////////////////////////////////////////

    // One pulse per request, hit or refill
    always_ff @(posedge i_clk, posedge i_reset) begin
        if (i_reset) begin
            done_q <= 1'b0;
        end else begin
            done_q <= hit_accept || refill_done;
        end
    end

    // Refill word bypasses the array
    always_ff @(posedge i_clk) begin
        if (refill_done) begin
            data_q <= i_mem_data;
        end else if (hit_accept) begin
            data_q <= data_mem[req_index];
        end
    end

    assign cache.done = done_q;
    assign cache.data = data_q;

endmodule

//--- source/miss_timer.sv
`timescale 1ns/100ps
`include "fetch_cfg.svh"

module miss_timer (
    input  logic i_clk,
    input  logic i_reset,
    input  logic i_start,
    output logic o_busy,
    output logic o_expired
);

    // Wide enough to hold the full latency
    localparam int CNT_W = $clog2(`FETCH_MISS_CYCLES + 1);

    logic [CNT_W-1:0] count_q;

    ////////////////////////////////////////
    // Refill down-counter
    ////////////////////////////////////////

    always_ff @(posedge i_clk, posedge i_reset) begin
        if (i_reset) begin
            count_q <= '0;
        end else if (i_start) begin
            count_q <= CNT_W'(`FETCH_MISS_CYCLES);
        end else if (count_q != '0) begin
            count_q <= count_q - 1'b1;
        end
    end

    // One busy cycle per count value
    assign o_busy    = (count_q != '0);
    // Last busy cycle, count hits zero on the next edge
    assign o_expired = (count_q == CNT_W'(1));

endmodule

//--- source/pc_counter.sv
`timescale 1ns/100ps
`include "fetch_cfg.svh"

module pc_counter (
    input  logic             i_clk,
    input  logic             i_reset,
    input  logic             i_step,
    input  logic             i_pc_load,
    input  fetch_pkg::word_t i_ext_pc,
    cache_if.pc              cache,
    output fetch_pkg::word_t o_pc
);

    fetch_pkg::fetch_addr_u pc_q;
    fetch_pkg::word_t       branch_pc;
    fetch_pkg::word_t       seq_pc;

    // Branch target forced even
    assign branch_pc = {i_ext_pc[`FETCH_XLEN-1:1], 1'b0};
    // Next sequential word
    assign seq_pc    = pc_q.raw + fetch_pkg::word_t'(`FETCH_WORD_BYTES);

    ////////////////////////////////////////
    // PC register
    ////////////////////////////////////////

    always_ff @(posedge i_clk, posedge i_reset) begin
        if (i_reset) begin
            pc_q.raw <= `FETCH_RESET_VECTOR;
        end else if (i_step) begin
            // Load wins over the sequential step
            if (i_pc_load) begin
                pc_q.raw <= branch_pc;
            end else begin
                pc_q.raw <= seq_pc;
            end
        end
    end

    // Whole union goes to the cache, it picks the fields
    assign cache.addr = pc_q;
    assign o_pc       = pc_q.raw;

endmodule
